//--- src/noc_chain_pkg.sv
// ========================================================================
// shared word types and constants for the NoC test chain
// ========================================================================

package noc_chain_pkg;

    // datapath width, same on every link
    localparam int noc_dw = 32;

    typedef logic [noc_dw-1:0] word_t;
    typedef logic [31:0] seq_t;

    // 4-tap FIR, index 0 weights the newest sample
    localparam logic [7:0] fir_coef [4] = '{8'd1, 8'd3, 8'd3, 8'd1};

    // scrambler
    localparam word_t scramble_key = 32'h5a3c_96e1;
    localparam int unsigned rot_amount = 5;
    // picked by seq mod 4
    localparam word_t round_const [4] = '{
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5
    };

    // OR'ed into the eight adder tree terms
    localparam word_t mask_const [8] = '{
        32'h67452301, 32'hefcdab89, 32'h98badcfe, 32'h10325476,
        32'hc3d2e1f0, 32'h5a827999, 32'h6ed9eba1, 32'h8f1bbcdc
    };

    // constant multiplier after the tree
    localparam word_t mask_mult = 32'd13;

endpackage

//--- src/traffic_generator.sv
// ========================================================================
// 4-tap FIR traffic source with a valid/ready output register
// ========================================================================
`timescale 1ns/10ps

module traffic_generator (
    input  logic                 clk,
    input  logic                 reset,
    input  noc_chain_pkg::word_t data_in,
    input  logic                 in_valid,
    output logic                 in_ready,
    output noc_chain_pkg::word_t tg_data,
    output logic                 tg_valid,
    input  logic                 tg_ready
);
    import noc_chain_pkg::*;

    // delay line, x1 is the previous accepted sample
    word_t x1;
    word_t x2;
    word_t x3;
    word_t fir_y;
    // low for the first cycle out of reset
    logic  started;
    logic  accept;

    // take a sample when the output slot is free or draining
    assign in_ready = started && (!tg_valid || tg_ready);
    assign accept   = in_valid && in_ready;

    // products wrap at 32 bits
    always_comb begin
        fir_y = word_t'(fir_coef[0]) * data_in
              + word_t'(fir_coef[1]) * x1
              + word_t'(fir_coef[2]) * x2
              + word_t'(fir_coef[3]) * x3;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            started  <= 1'b0;
            tg_valid <= 1'b0;
            x1       <= '0;
            x2       <= '0;
            x3       <= '0;
        end else begin
            started <= 1'b1;
            if (accept) begin
                // history only moves on accepted samples
                x1       <= data_in;
                x2       <= x1;
                x3       <= x2;
                tg_valid <= 1'b1;
            end else if (tg_ready) begin
                tg_valid <= 1'b0;
            end
        end
    end

    // result word, held while stalled
    always_ff @(posedge clk) begin
        if (accept) begin
            tg_data <= fir_y;
        end
    end

endmodule

//--- src/master_interface.sv
// ========================================================================
// four-phase sender taking one word at a time from the FIR stream
// ========================================================================
`timescale 1ns/10ps

module master_interface (
    input  logic                 clk,
    input  logic                 reset,
    input  noc_chain_pkg::word_t tg_data,
    input  logic                 tg_valid,
    output logic                 tg_ready,
    output noc_chain_pkg::word_t link_data,
    output logic                 link_req,
    input  logic                 link_ack
);

    typedef enum logic [1:0] {
        M_IDLE,
        M_REQ,
        M_RELEASE
    } m_state_t;

    m_state_t state;

    // a new word only enters between transfers
    assign tg_ready = (state == M_IDLE);
    assign link_req = (state == M_REQ);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= M_IDLE;
        end else begin
            case (state)
                M_IDLE: if (tg_valid) state <= M_REQ;
                // wait for the receiver to capture
                M_REQ: if (link_ack) state <= M_RELEASE;
                // req is low now, wait for ack to follow
                M_RELEASE: if (!link_ack) state <= M_IDLE;
                default: state <= M_IDLE;
            endcase
        end
    end

    // bus stays stable for the whole req phase
    always_ff @(posedge clk) begin
        if (state == M_IDLE && tg_valid) begin
            link_data <= tg_data;
        end
    end

endmodule

//--- src/noc_link_adapter.sv
// ========================================================================
// router hop: four-phase receiver, circular FIFO, four-phase sender
// ========================================================================
`timescale 1ns/10ps

module noc_link_adapter #(
    parameter int FIFO_DEPTH = 2,
    parameter int DATA_W     = noc_chain_pkg::noc_dw
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [DATA_W-1:0] rx_data,
    input  logic              rx_req,
    output logic              rx_ack,
    output logic [DATA_W-1:0] tx_data,
    output logic              tx_req,
    input  logic              tx_ack
);

    // pointer needs at least one bit
    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    logic [DATA_W-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [CW-1:0]     count;
    logic              push;
    logic              pop;

    // ack withheld while full, which backs up the upstream link
    assign push = rx_req && !rx_ack && (count != CW'(FIFO_DEPTH));
    // launch only when the previous transfer is fully released
    assign pop  = !tx_req && !tx_ack && (count != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_ack <= 1'b0;
            tx_req <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // receiver side
            if (push) begin
                rx_ack <= 1'b1;
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
            end else if (rx_ack && !rx_req) begin
                rx_ack <= 1'b0;
            end
            // sender side
            if (pop) begin
                tx_req <= 1'b1;
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
            end else if (tx_req && tx_ack) begin
                tx_req <= 1'b0;
            end
            count <= count + CW'(push) - CW'(pop);
        end
    end

    // storage and outgoing bus
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= rx_data;
        end
        if (pop) begin
            tx_data <= mem[rd_ptr];
        end
    end

endmodule

//--- src/slave_interface.sv
// ========================================================================
// four-phase receiver, one-cycle valid pulse per flit
// ========================================================================
`timescale 1ns/10ps

module slave_interface (
    input  logic                 clk,
    input  logic                 reset,
    input  noc_chain_pkg::word_t link_data,
    input  logic                 link_req,
    output logic                 link_ack,
    output noc_chain_pkg::word_t s_data,
    output logic                 s_valid
);

    logic capture;

    // new flit: req up, ack not yet given
    assign capture = link_req && !link_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            link_ack <= 1'b0;
            s_valid  <= 1'b0;
        end else begin
            // sink is always ready, so no stall here
            s_valid <= capture;
            if (capture) begin
                link_ack <= 1'b1;
            end else if (link_ack && !link_req) begin
                // sender released, close the handshake
                link_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            s_data <= link_data;
        end
    end

endmodule

//--- src/traffic_processor.sv
// ========================================================================
// word scrambler with round constant and delivered-word counter
// ========================================================================
`timescale 1ns/10ps

module traffic_processor (
    input  logic                 clk,
    input  logic                 reset,
    input  noc_chain_pkg::word_t s_data,
    input  logic                 s_valid,
    output noc_chain_pkg::word_t enc_data,
    output noc_chain_pkg::seq_t  seq,
    output logic                 tp_valid
);
    import noc_chain_pkg::*;

    // words delivered so far
    seq_t  word_count;
    word_t mixed;

    function automatic word_t rotl(input word_t x, input int unsigned n);
        return (x << n) | (x >> (noc_dw - n));
    endfunction

    // key xor, rotate, then add the round constant for this slot
    always_comb begin
        mixed = rotl(s_data ^ scramble_key, rot_amount)
              + round_const[word_count[1:0]];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            word_count <= '0;
            tp_valid   <= 1'b0;
        end else begin
            tp_valid <= s_valid;
            if (s_valid) begin
                word_count <= word_count + seq_t'(1);
            end
        end
    end

    // seq tags the word with its own index, starting at 0
    always_ff @(posedge clk) begin
        if (s_valid) begin
            enc_data <= mixed;
            seq      <= word_count;
        end
    end

endmodule

//--- src/spread_mask_stage.sv
// ========================================================================
// 3-stage adder tree and multiplier building the output mask
// ========================================================================
`timescale 1ns/10ps

module spread_mask_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  noc_chain_pkg::word_t enc_data,
    input  noc_chain_pkg::seq_t  seq,
    input  logic                 tp_valid,
    output noc_chain_pkg::word_t data_out,
    output logic                 out_valid
);
    import noc_chain_pkg::*;

    word_t term [8];
    word_t pair_sum [4];
    word_t tree_sum;
    word_t mask;
    // word travelling next to its mask
    word_t enc_s1;
    word_t enc_s2;
    logic  valid_s1;
    logic  valid_s2;

    // eight terms off the sequence number
    always_comb begin
        term[0] = seq | mask_const[0];
        for (int i = 1; i < 8; i++) begin
            term[i] = (word_t'(i) * seq + word_t'(i)) | mask_const[i];
        end
    end

    assign mask = tree_sum * mask_mult;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_s1  <= 1'b0;
            valid_s2  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            valid_s1  <= tp_valid;
            valid_s2  <= valid_s1;
            out_valid <= valid_s2;
        end
    end

    always_ff @(posedge clk) begin
        // stage 1, pairwise adds
        for (int k = 0; k < 4; k++) begin
            pair_sum[k] <= term[2*k] + term[2*k+1];
        end
        enc_s1 <= enc_data;
        // stage 2, sum of pairs
        tree_sum <= pair_sum[0] + pair_sum[1] + pair_sum[2] + pair_sum[3];
        enc_s2   <= enc_s1;
        // stage 3, multiply and mask
        data_out <= enc_s2 & mask;
    end

endmodule

//--- src/spread_noc_chain.sv
// ========================================================================
// chain top: FIR source, two router hops, scrambler and mask stage
// ========================================================================
`timescale 1ns/10ps

module spread_noc_chain #(
    parameter int FIFO_DEPTH = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  noc_chain_pkg::word_t data_in,
    input  logic                 in_valid,
    output logic                 in_ready,
    output noc_chain_pkg::word_t data_out,
    output logic                 out_valid
);
    import noc_chain_pkg::*;

    // FIR to master
    word_t tg_data;
    logic  tg_valid;
    logic  tg_ready;
    // master to hop one
    word_t m_data;
    logic  m_req;
    logic  m_ack;
    // hop one to hop two
    word_t h1_data;
    logic  h1_req;
    logic  h1_ack;
    // hop two to slave
    word_t h2_data;
    logic  h2_req;
    logic  h2_ack;
    // output side
    word_t s_data;
    logic  s_valid;
    word_t enc_data;
    seq_t  seq;
    logic  tp_valid;

    traffic_generator tg (
        .clk, .reset, .data_in, .in_valid, .in_ready,
        .tg_data, .tg_valid, .tg_ready
    );

    master_interface mi (
        .clk, .reset, .tg_data, .tg_valid, .tg_ready,
        .link_data(m_data), .link_req(m_req), .link_ack(m_ack)
    );

    noc_link_adapter #(.FIFO_DEPTH(FIFO_DEPTH), .DATA_W(noc_dw)) hop_one (
        .clk, .reset,
        .rx_data(m_data), .rx_req(m_req), .rx_ack(m_ack),
        .tx_data(h1_data), .tx_req(h1_req), .tx_ack(h1_ack)
    );

    noc_link_adapter #(.FIFO_DEPTH(FIFO_DEPTH), .DATA_W(noc_dw)) hop_two (
        .clk, .reset,
        .rx_data(h1_data), .rx_req(h1_req), .rx_ack(h1_ack),
        .tx_data(h2_data), .tx_req(h2_req), .tx_ack(h2_ack)
    );

    slave_interface si (
        .clk, .reset,
        .link_data(h2_data), .link_req(h2_req), .link_ack(h2_ack),
        .s_data, .s_valid
    );

    traffic_processor tp (
        .clk, .reset, .s_data, .s_valid, .enc_data, .seq, .tp_valid
    );

    // mask follows the delivered sequence number
    spread_mask_stage sm (
        .clk, .reset, .enc_data, .seq, .tp_valid, .data_out, .out_valid
    );

endmodule

//--- tb/noc_chain_ref.svh
// ========================================================================
// reference model: FIR, scrambler, sequence mask and expected output word
// ========================================================================
`ifndef NOC_CHAIN_REF_SVH
`define NOC_CHAIN_REF_SVH

// y[n] = 1*x[n] + 3*x[n-1] + 3*x[n-2] + 1*x[n-3], wraps at 32 bits
function automatic word_t ref_fir(input word_t x0, input word_t x1,
                                  input word_t x2, input word_t x3);
    word_t acc;
    acc = word_t'(fir_coef[0]) * x0;
    acc = acc + word_t'(fir_coef[1]) * x1;
    acc = acc + word_t'(fir_coef[2]) * x2;
    acc = acc + word_t'(fir_coef[3]) * x3;
    return acc;
endfunction

// xor key, rotate left, add round constant picked by seq mod 4
function automatic word_t ref_scramble(input word_t w, input seq_t s);
    word_t v;
    v = w ^ scramble_key;
    v = (v << rot_amount) | (v >> (32 - rot_amount));
    return v + round_const[s % 4];
endfunction

// eight terms, summed, then times the multiplier
function automatic word_t ref_mask(input seq_t s);
    word_t sum;
    sum = s | mask_const[0];
    for (int i = 1; i < 8; i++) begin
        sum = sum + ((word_t'(i) * s + word_t'(i)) | mask_const[i]);
    end
    return sum * mask_mult;
endfunction

function automatic word_t ref_expected(input word_t fir_y, input seq_t s);
    return ref_scramble(fir_y, s) & ref_mask(s);
endfunction

`endif

//--- tb/tb_spread_noc_chain.sv
// ========================================================================
// testbench for the NoC chain: stimulus, reference scoreboard, timeout
// ========================================================================
`timescale 1ns/10ps

module tb_spread_noc_chain;
    import noc_chain_pkg::*;

    `include "noc_chain_ref.svh"

    localparam int impulse_len    = 6;
    localparam int stream_len     = 200;
    localparam int gap_len        = 120;
    localparam int total_samples  = impulse_len + stream_len + gap_len;
    localparam int timeout_cycles = total_samples * 12 + 200;

    logic  clk;
    logic  reset;
    word_t data_in;
    logic  in_valid;
    logic  in_ready;
    word_t data_out;
    logic  out_valid;

    // scoreboard state
    word_t exp_q [$];
    string name_q [$];
    word_t hist [3];
    int    accepted;
    int    delivered;
    int    stall_cycles;
    int    cycle_count;
    int    seed;

    spread_noc_chain #(.FIFO_DEPTH(2)) UUT (
        .clk, .reset, .data_in, .in_valid, .in_ready, .data_out, .out_valid
    );

    // 8 ns period
    always #4 clk = ~clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_count(input string name, input seq_t expected, input seq_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAIL %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    // test that produced accepted sample number idx
    function automatic string phase_name(input int idx);
        if (idx < impulse_len) begin
            return "impulse";
        end else if (idx < impulse_len + stream_len) begin
            return "stream";
        end
        return "gaps";
    endfunction

    // optional idle cycles, then hold the sample until it is taken
    task automatic feed_word(input word_t value, input int gap);
        for (int i = 0; i < gap; i++) begin
            in_valid <= 1'b0;
            @(posedge clk);
        end
        data_in  <= value;
        in_valid <= 1'b1;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
    endtask

    // reference side, follows every accepted sample in order
    always @(posedge clk) begin : accept_monitor
        word_t y;
        if (!reset && in_valid && in_ready) begin
            y = ref_fir(data_in, hist[0], hist[1], hist[2]);
            exp_q.push_back(ref_expected(y, seq_t'(accepted)));
            name_q.push_back(phase_name(accepted));
            hist[2] = hist[1];
            hist[1] = hist[0];
            hist[0] = data_in;
            accepted++;
        end
        // chain busy, upstream held off
        if (!reset && in_valid && !in_ready) begin
            stall_cycles++;
        end
    end

    // compare each delivered word against the oldest expected one
    always @(posedge clk) begin
        if (!reset && out_valid) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("out_valid rose with no word outstanding, extra output");
            end else begin
                check_word(name_q.pop_front(), exp_q.pop_front(), data_out);
                delivered++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            stop_with_failure($sformatf("outputs stalled: %0d of %0d words after %0d cycles",
                                        delivered, accepted, cycle_count));
        end
    end

    initial begin
        int gap;
        clk          = 1'b0;
        reset        = 1'b1;
        data_in      = '0;
        in_valid     = 1'b0;
        accepted     = 0;
        delivered    = 0;
        stall_cycles = 0;
        cycle_count  = 0;
        seed         = 70860;
        hist         = '{default: '0};

        // outputs are unknown until the first reset edge
        @(posedge clk);
        repeat (7) begin
            @(posedge clk);
            if (out_valid !== 1'b0) stop_with_failure("out_valid was high during reset");
        end
        reset <= 1'b0;
        @(posedge clk);
        // first cycle out of reset
        if (out_valid !== 1'b0) stop_with_failure("out_valid was high right after reset");
        if (in_ready !== 1'b0) stop_with_failure("in_ready was high right after reset");

        // impulse, then zeros flush the taps
        feed_word(32'd1, 0);
        for (int i = 1; i < impulse_len; i++) begin
            feed_word('0, 0);
        end

        // back to back random words
        for (int i = 0; i < stream_len; i++) begin
            feed_word($random(seed), 0);
        end

        // random idle gaps between samples
        for (int i = 0; i < gap_len; i++) begin
            gap = (($random(seed) & 3) == 0) ? 1 + ($random(seed) & 3) : 0;
            feed_word($random(seed), gap);
        end
        in_valid <= 1'b0;

        while (delivered != accepted) begin
            @(posedge clk);
        end
        // catch any late duplicate
        repeat (20) @(posedge clk);

        check_count("accepted", seq_t'(total_samples), seq_t'(accepted));
        check_count("completeness", seq_t'(accepted), seq_t'(delivered));
        if (stall_cycles == 0) stop_with_failure("in_ready never dropped while samples waited");

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- flist.f
+incdir+tb
src/noc_chain_pkg.sv
src/traffic_generator.sv
src/master_interface.sv
src/noc_link_adapter.sv
src/slave_interface.sv
src/traffic_processor.sv
src/spread_mask_stage.sv
src/spread_noc_chain.sv
tb/tb_spread_noc_chain.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the NoC chain testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing -f flist.f --top-module tb_spread_noc_chain \
    --Mdir obj_dir -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "build or simulation exited with an error, see build.log and sim.log"

grep -qx "RESULT: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
